// ==== hw/histCfgPkg.sv ====
`default_nettype none

package histCfgPkg;

    // raw TDC timestamp as delivered by the pixel
    localparam int timeBits = 16;

    // top field of the timestamp, picks the coarse bin
    localparam int coarseBits = 6;

    // next field down, picks the fine bin
    localparam int fineBits = 6;

    // leftover low bits below the fine field
    localparam int subBits = timeBits - coarseBits - fineBits;

    // per-bin counter width
    localparam int countBits = 12;

    // coarse and fine histograms have the same depth
    localparam int binNum = 1 << coarseBits;

endpackage

`default_nettype wire

// ==== hw/peakTypesPkg.sv ====
`default_nettype none

package peakTypesPkg;

    // timestamp split into its histogram indices
    typedef struct packed {
        logic [histCfgPkg::coarseBits-1:0] coarse;
        logic [histCfgPkg::fineBits-1:0]   fine;
        logic [histCfgPkg::subBits-1:0]    sub;     // below fine resolution, unused
    } tdcFields;

    // same TDC word, either as plain bits or as bin fields
    typedef union packed {
        logic [histCfgPkg::timeBits-1:0] raw;
        tdcFields                        fields;
    } tdcWord;

    // current maximum of one histogram
    typedef struct packed {
        logic [histCfgPkg::coarseBits-1:0] bin;
        logic [histCfgPkg::countBits-1:0]  count;
    } peakInfo;

    // frame result; estimate is coarse bin then fine bin
    typedef struct packed {
        logic [histCfgPkg::coarseBits+histCfgPkg::fineBits-1:0] estimate;
        peakInfo                                                coarsePeak;
        peakInfo                                                finePeak;
        logic                                                   noSignal;
    } peakResult;

endpackage

`default_nettype wire

// ==== hw/histRam.sv ====
`timescale 1ns/10ps
`default_nettype none

module histRam (
    input  wire                                clk,
    input  wire                                wrEn,
    input  wire  [histCfgPkg::coarseBits-1:0]  wrAddr,
    input  wire  [histCfgPkg::countBits-1:0]   wrData,
    input  wire  [histCfgPkg::coarseBits-1:0]  rdAddr,
    output logic [histCfgPkg::countBits-1:0]   rdData
);

    // one count per bin
    logic [histCfgPkg::countBits-1:0] mem [histCfgPkg::binNum];

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddr] <= wrData;
        end
    end

    // registered read, returns the old word on a same-edge write
    always_ff @(posedge clk) begin
        rdData <= mem[rdAddr];
    end

endmodule

`default_nettype wire

// ==== hw/histBuilder.sv ====
`timescale 1ns/10ps
`default_nettype none

module histBuilder #(
    parameter bit useFine = 1'b0           // 0 indexes by coarse field, 1 by fine field
) (
    input  wire                               clk,
    input  wire                               res,
    input  wire                               clearEn,
    input  wire  [histCfgPkg::coarseBits-1:0] clearAddr,
    input  wire                               accept,
    input  wire  peakTypesPkg::tdcWord        eventWord,
    output peakTypesPkg::peakInfo             peak,
    output logic                              clearDone
);

    localparam int binW = histCfgPkg::coarseBits;
    localparam int cntW = histCfgPkg::countBits;

    logic [binW-1:0] evBin;               // bin of the incoming event

    // stage 1 waits for RAM data, stage 2 writes, stage 3 holds the last write
    logic            s1Valid;
    logic [binW-1:0] s1Bin;
    logic            s2Valid;
    logic [binW-1:0] s2Bin;
    logic [cntW-1:0] s2Count;
    logic            s3Valid;
    logic [binW-1:0] s3Bin;
    logic [cntW-1:0] s3Count;

    logic [cntW-1:0] baseCount;           // count before this event
    logic            ramWrEn;
    logic [binW-1:0] ramWrAddr;
    logic [cntW-1:0] ramWrData;
    logic [cntW-1:0] ramRdData;

    if (useFine) begin : gFineSel
        assign evBin = eventWord.fields.fine;
    end else begin : gCoarseSel
        assign evBin = eventWord.fields.coarse;
    end

    // last bin of the sweep, both builders run it in lockstep
    assign clearDone = clearEn && (clearAddr == binW'(histCfgPkg::binNum - 1));

    // clear sweep owns the write port, otherwise stage 2 does
    assign ramWrEn   = clearEn | s2Valid;
    assign ramWrAddr = clearEn ? clearAddr : s2Bin;
    assign ramWrData = clearEn ? '0 : s2Count;

    histRam ram (
        .clk    (clk),
        .wrEn   (ramWrEn),
        .wrAddr (ramWrAddr),
        .wrData (ramWrData),
        .rdAddr (evBin),
        .rdData (ramRdData)
    );

    // RAM data misses the write in flight and the one landing on the read edge
    always_comb begin
        if (s2Valid && (s2Bin == s1Bin)) begin
            baseCount = s2Count;
        end else if (s3Valid && (s3Bin == s1Bin)) begin
            baseCount = s3Count;
        end else begin
            baseCount = ramRdData;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            s3Valid <= 1'b0;
        end else begin
            s1Valid <= accept & ~clearEn;
            s2Valid <= s1Valid;
            s3Valid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Bin   <= evBin;
        s2Bin   <= s1Bin;
        s2Count <= baseCount + cntW'(1);
        s3Bin   <= s2Bin;
        s3Count <= s2Count;
    end

    // strictly greater, so the first bin to reach the max keeps it
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            peak <= '0;
        end else if (clearEn) begin
            peak <= '0;
        end else if (s2Valid && (s2Count > peak.count)) begin
            peak.bin   <= s2Bin;
            peak.count <= s2Count;
        end
    end

    // frame length is bounded by the sequencer, so a bin can never overflow
    countWrap: assert property (
        @(posedge clk) disable iff (!res)
        s2Valid |-> (s2Count != '0)
    ) else $error("histBuilder: bin %0d count wrapped", s2Bin);

endmodule

`default_nettype wire

// ==== hw/frameSequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module frameSequencer #(
    parameter int frameEvents = 256        // events accepted per frame
) (
    input  wire                               clk,
    input  wire                               res,
    input  wire                               start,
    input  wire                               eventValid,
    input  wire                               clearDone,
    output logic                              clearEn,
    output logic [histCfgPkg::coarseBits-1:0] clearAddr,
    output logic                              accept,
    output logic                              tdcEnable,
    output logic                              busy,
    output logic                              frameDone
);

    localparam int cntW = histCfgPkg::countBits;
    localparam logic [cntW-1:0] lastEvent = cntW'(frameEvents - 1);

    typedef enum logic [2:0] {
        stIdle,
        stClear,
        stAccum,
        stDrain,
        stDone
    } seqState;

    seqState         state;
    logic [cntW-1:0] evCount;             // events accepted so far
    logic            drainCnt;            // two cycles of pipeline drain

    assign clearEn   = (state == stClear);
    assign tdcEnable = (state == stAccum);
    assign accept    = tdcEnable & eventValid;
    assign busy      = (state != stIdle);
    assign frameDone = (state == stDone);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= stIdle;
            clearAddr <= '0;
            evCount   <= '0;
            drainCnt  <= 1'b0;
        end else begin
            case (state)
                stIdle: begin
                    if (start) begin          // start is ignored in every other state
                        state     <= stClear;
                        clearAddr <= '0;
                    end
                end
                stClear: begin
                    clearAddr <= clearAddr + 1'b1;
                    if (clearDone) begin
                        state   <= stAccum;
                        evCount <= '0;
                    end
                end
                stAccum: begin
                    if (accept) begin
                        evCount <= evCount + cntW'(1);
                        if (evCount == lastEvent) begin
                            state    <= stDrain;
                            drainCnt <= 1'b0;
                        end
                    end
                end
                stDrain: begin
                    drainCnt <= 1'b1;
                    if (drainCnt) begin
                        state <= stDone;  // last write done, peak settles here
                    end
                end
                stDone: state <= stIdle;
                default: state <= stIdle;
            endcase
        end
    end

    // builder counts are only safe if a whole frame fits in one bin
    frameFits: assert property (
        @(posedge clk) disable iff (!res)
        start |-> (frameEvents > 0) && (frameEvents < (1 << cntW))
    ) else $error("frameSequencer: frameEvents %0d exceeds count width", frameEvents);

endmodule

`default_nettype wire

// ==== hw/peakCombiner.sv ====
`timescale 1ns/10ps
`default_nettype none

module peakCombiner #(
    parameter int minPeak = 8              // coarse count needed to call it a signal
) (
    input  wire                        clk,
    input  wire                        res,
    input  wire                        frameDone,
    input  wire peakTypesPkg::peakInfo coarsePeak,
    input  wire peakTypesPkg::peakInfo finePeak,
    output peakTypesPkg::peakResult    result,
    output logic                       resultValid
);

    localparam int cntW = histCfgPkg::countBits;
    localparam logic [cntW-1:0] minCount = cntW'(minPeak);

    logic lowPeak;                        // coarse peak too weak to trust

    assign lowPeak = (coarsePeak.count < minCount);

    // result holds until the next frame completes
    always_ff @(posedge clk) begin
        if (frameDone) begin
            result.estimate   <= {coarsePeak.bin, finePeak.bin};
            result.coarsePeak <= coarsePeak;
            result.finePeak   <= finePeak;
            result.noSignal   <= lowPeak;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= frameDone;     // one pulse per frame
        end
    end

endmodule

`default_nettype wire

// ==== hw/sifhTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module sifhTop #(
    parameter int frameEvents = 256,
    parameter int minPeak     = 8
) (
    input  wire                        clk,
    input  wire                        res,
    input  wire                        start,
    input  wire                        eventValid,
    input  wire peakTypesPkg::tdcWord  eventWord,
    output logic                       tdcEnable,
    output logic                       busy,
    output peakTypesPkg::peakResult    result,
    output logic                       resultValid
);

    logic                              clearEn;
    logic [histCfgPkg::coarseBits-1:0] clearAddr;
    logic                              clearDone;
    logic                              accept;
    logic                              frameDone;
    peakTypesPkg::peakInfo             coarsePeak;
    peakTypesPkg::peakInfo             finePeak;

    frameSequencer #(
        .frameEvents (frameEvents)
    ) sequencer (
        .clk        (clk),
        .res        (res),
        .start      (start),
        .eventValid (eventValid),
        .clearDone  (clearDone),
        .clearEn    (clearEn),
        .clearAddr  (clearAddr),
        .accept     (accept),
        .tdcEnable  (tdcEnable),
        .busy       (busy),
        .frameDone  (frameDone)
    );

    histBuilder #(
        .useFine (1'b0)
    ) coarseHist (
        .clk       (clk),
        .res       (res),
        .clearEn   (clearEn),
        .clearAddr (clearAddr),
        .accept    (accept),
        .eventWord (eventWord),
        .peak      (coarsePeak),
        .clearDone (clearDone)
    );

    histBuilder #(
        .useFine (1'b1)
    ) fineHist (
        .clk       (clk),
        .res       (res),
        .clearEn   (clearEn),
        .clearAddr (clearAddr),
        .accept    (accept),
        .eventWord (eventWord),
        .peak      (finePeak),
        .clearDone ()                     // same timing as the coarse builder
    );

    peakCombiner #(
        .minPeak (minPeak)
    ) combiner (
        .clk         (clk),
        .res         (res),
        .frameDone   (frameDone),
        .coarsePeak  (coarsePeak),
        .finePeak    (finePeak),
        .result      (result),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

// ==== tests/sifhModel.svh ====
`ifndef SIFH_MODEL_SVH
`define SIFH_MODEL_SVH

// one table row describes the events of one frame
typedef struct {
    int center;                           // pulse timestamp
    int spread;                           // jitter in raw counts, both ways
    int sigPct;                           // share of events from the pulse
    int gapPct;                           // chance of an idle cycle
    int events;                           // accepted events per frame
    int altStamp;                         // >= 0 alternates with center, for ties
    bit extras;                           // strays in clear and drain, start while busy
} frameRow;

logic [cntW-1:0]       coarseRef [histCfgPkg::binNum];
logic [cntW-1:0]       fineRef [histCfgPkg::binNum];
peakTypesPkg::peakInfo coarseMax;
peakTypesPkg::peakInfo fineMax;

function automatic void modelClear();
    foreach (coarseRef[i]) begin
        coarseRef[i] = '0;
        fineRef[i]   = '0;
    end
    coarseMax = '0;                       // bin 0, count 0
    fineMax   = '0;
endfunction

// coarse is the top field of the stamp, fine the field right below it
function automatic void modelAdd(input logic [timeW-1:0] ts);
    logic [binW-1:0] cb;
    logic [binW-1:0] fb;
    cb = binW'(ts >> (timeW - histCfgPkg::coarseBits));
    fb = binW'(ts >> (timeW - histCfgPkg::coarseBits - histCfgPkg::fineBits));
    coarseRef[cb] = coarseRef[cb] + cntW'(1);
    fineRef[fb]   = fineRef[fb] + cntW'(1);
    if (coarseRef[cb] > coarseMax.count) begin     // first bin at the max keeps it
        coarseMax.bin   = cb;
        coarseMax.count = coarseRef[cb];
    end
    if (fineRef[fb] > fineMax.count) begin
        fineMax.bin   = fb;
        fineMax.count = fineRef[fb];
    end
endfunction

function automatic peakTypesPkg::peakResult modelResult();
    peakTypesPkg::peakResult r;
    r.coarsePeak = coarseMax;
    r.finePeak   = fineMax;
    r.estimate   = {coarseMax.bin, fineMax.bin};
    r.noSignal   = (int'(coarseMax.count) < minPeak);
    return r;
endfunction

function automatic logic [timeW-1:0] genStamp(input frameRow row, input int idx);
    int off;
    if (row.altStamp >= 0) begin
        return (idx % 2 == 0) ? timeW'(row.altStamp) : timeW'(row.center);
    end
    if (int'($urandom_range(99, 0)) < row.sigPct) begin
        off = int'($urandom_range(2 * row.spread, 0)) - row.spread;
        return timeW'(row.center + off);
    end
    return timeW'($urandom);              // background noise, any stamp
endfunction

`endif

// ==== tests/sifhTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module sifhTb;

    localparam int clkPeriod   = 100;
    localparam int resetCycles = 8;
    localparam int frameLen    = 64;      // short frames keep the run quick
    localparam int minPeak     = 8;
    localparam int timeW       = histCfgPkg::timeBits;
    localparam int binW        = histCfgPkg::coarseBits;
    localparam int cntW        = histCfgPkg::countBits;

    logic                    clk = 1'b0;
    logic                    res;
    logic                    start;
    logic                    eventValid;
    peakTypesPkg::tdcWord    eventWord;
    logic                    tdcEnable;
    logic                    busy;
    peakTypesPkg::peakResult result;
    logic                    resultValid;

    int peakErrors   = 0;
    int resultErrors = 0;
    int flowErrors   = 0;

    `include "sifhModel.svh"

    // center, spread, signal %, gap %, events, alternate stamp, strays
    frameRow frames [6] = '{
        '{'h5a37,  8,  90, 20, frameLen, -1, 1'b0},       // strong narrow pulse
        '{'h0000,  0,   0, 30, frameLen, -1, 1'b0},       // noise only, weak peak
        '{'h8421,  0, 100,  0, frameLen, -1, 1'b0},       // one bin, every cycle
        '{'h2450,  0, 100, 25, frameLen, 'hc8a0, 1'b0},   // two bins tie
        '{'h3f80, 40,  70, 10, frameLen, -1, 1'b1},
        '{'hf00f, 20,  60, 40, frameLen, -1, 1'b0}
    };

    sifhTop #(
        .frameEvents (frameLen),
        .minPeak     (minPeak)
    ) dut0 (
        .clk         (clk),
        .res         (res),
        .start       (start),
        .eventValid  (eventValid),
        .eventWord   (eventWord),
        .tdcEnable   (tdcEnable),
        .busy        (busy),
        .result      (result),
        .resultValid (resultValid)
    );

    always #(clkPeriod / 2) clk = ~clk;

    task automatic checkPeak(input peakTypesPkg::peakInfo got,
                             input peakTypesPkg::peakInfo exp,
                             input string name, input int frameNo);
        if (got !== exp) begin
            peakErrors++;
            $display("ERR %0t frame %0d %s peak bin %0d count %0d, expected bin %0d count %0d",
                     $time, frameNo, name, got.bin, got.count, exp.bin, exp.count);
        end
    endtask

    task automatic checkResult(input peakTypesPkg::peakResult got,
                               input peakTypesPkg::peakResult exp, input int frameNo);
        if (got.estimate !== exp.estimate || got.noSignal !== exp.noSignal) begin
            resultErrors++;
            $display("ERR %0t frame %0d estimate %h noSignal %b, expected %h noSignal %b",
                     $time, frameNo, got.estimate, got.noSignal, exp.estimate, exp.noSignal);
        end
    endtask

    // entered and left on a falling edge
    task automatic runFrame(input frameRow row, input int frameNo);
        int waited;
        int accepted;
        peakTypesPkg::peakResult expected;
        modelClear();
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        if (!busy) begin
            flowErrors++;
            $display("frame %0d: busy did not rise after start", frameNo);
        end
        waited = 0;
        while (!tdcEnable && waited <= histCfgPkg::binNum) begin
            eventValid    = row.extras;   // must not count during clear
            eventWord.raw = timeW'(row.center);
            start         = row.extras && (waited == 10);
            @(negedge clk);
            waited++;
        end
        start = 1'b0;
        if (waited != histCfgPkg::binNum) begin
            flowErrors++;
            $display("frame %0d: tdcEnable came %0d cycles after start instead of %0d",
                     frameNo, waited, histCfgPkg::binNum);
        end
        accepted = 0;
        while (accepted < row.events) begin
            if (!tdcEnable) begin
                flowErrors++;
                $display("frame %0d: tdcEnable dropped after %0d of %0d events",
                         frameNo, accepted, row.events);
                break;
            end
            if (int'($urandom_range(99, 0)) < row.gapPct) begin
                eventValid = 1'b0;
            end else begin
                eventWord.raw = genStamp(row, accepted);
                eventValid    = 1'b1;
                modelAdd(eventWord.raw);
                accepted++;
            end
            @(negedge clk);
        end
        if (tdcEnable) begin
            flowErrors++;
            $display("frame %0d: tdcEnable still high after the last event", frameNo);
        end
        waited = 0;
        while (!resultValid && waited < 16) begin
            eventValid    = row.extras;
            eventWord.raw = timeW'(row.center);
            start         = row.extras && busy;     // only while the engine is busy
            @(negedge clk);
            waited++;
        end
        eventValid = 1'b0;
        start      = 1'b0;
        if (!resultValid) begin
            flowErrors++;
            $display("frame %0d: no resultValid within 16 cycles of the last event", frameNo);
        end else begin
            expected = modelResult();
            checkPeak(result.coarsePeak, expected.coarsePeak, "coarse", frameNo);
            checkPeak(result.finePeak, expected.finePeak, "fine", frameNo);
            checkResult(result, expected, frameNo);
        end
    endtask

    initial begin : mainSeq
        void'($urandom(32'h71e2));
        res        = 1'b0;
        start      = 1'b0;
        eventValid = 1'b0;
        eventWord  = '0;
        repeat (resetCycles) @(negedge clk);
        res = 1'b1;
        @(negedge clk);
        if (tdcEnable || busy || resultValid) begin
            flowErrors++;
            $display("outputs are not idle after reset");
        end
        foreach (frames[i]) begin
            runFrame(frames[i], i);
        end
        $display("errors: peak %0d, result %0d, protocol %0d",
                 peakErrors, resultErrors, flowErrors);
        if (peakErrors + resultErrors + flowErrors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    // clear sweep plus events per frame, four cycles per event covers the gaps
    initial begin : watchdog
        longint limit;
        #1;
        limit = resetCycles + 10;
        foreach (frames[i]) begin
            limit += histCfgPkg::binNum + 16 + 4 * frames[i].events;
        end
        #(limit * clkPeriod);
        $display("timeout: the run did not finish within %0d cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+tests
hw/histCfgPkg.sv
hw/peakTypesPkg.sv
hw/histRam.sv
hw/histBuilder.sv
hw/frameSequencer.sv
hw/peakCombiner.sv
hw/sifhTop.sv
tests/sifhTb.sv

// ==== Makefile ====
VERILATOR := verilator
TOP       := sifhTb
FILELIST  := sources.f
FLAGS     := --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS := --lint-only --timing -Wall
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

# the run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "sim passed"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)
